/* source/dma_pkg.sv */
/*
 * DMA engine shared definitions
 * Widths, register map and the structs for buses, transfers and rows
 */
package dma_pkg;

  localparam int unsigned ADDR_WIDTH     = 32;
  localparam int unsigned DATA_WIDTH     = 32;
  localparam int unsigned ID_WIDTH       = 28;
  localparam int unsigned REG_ADDR_WIDTH = 10;

  // Byte offsets on the configuration port
  typedef enum logic [REG_ADDR_WIDTH-1:0] {
    reg_src        = 10'h000,
    reg_dst        = 10'h004,
    reg_len        = 10'h008,
    reg_src_stride = 10'h00C,
    reg_dst_stride = 10'h010,
    reg_reps       = 10'h014,
    reg_next_id    = 10'h018,
    reg_done_id    = 10'h01C,
    reg_status     = 10'h020
  } reg_addr_e;

  // ------------------------------------------------------------------------
  // Configuration port
  // ------------------------------------------------------------------------

  typedef struct packed {
    logic                      req;
    logic                      we;
    logic [REG_ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0]     wdata;
  } cfg_req_t;

  typedef struct packed {
    logic                  gnt;
    logic                  rvalid;
    logic [DATA_WIDTH-1:0] rdata;
  } cfg_rsp_t;

  // ------------------------------------------------------------------------
  // Transfers and rows
  // ------------------------------------------------------------------------

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] src;
    logic [ADDR_WIDTH-1:0] dst;
    logic [ADDR_WIDTH-1:0] len;
    logic [ADDR_WIDTH-1:0] src_stride;
    logic [ADDR_WIDTH-1:0] dst_stride;
    logic [DATA_WIDTH-1:0] reps;
  } xfer_2d_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] src;
    logic [ADDR_WIDTH-1:0] dst;
    logic [ADDR_WIDTH-1:0] len;
    logic                  last;
  } row_req_t;

  // ------------------------------------------------------------------------
  // Memory ports
  // ------------------------------------------------------------------------

  typedef struct packed {
    logic                  req;
    logic                  we;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                  gnt;
    logic                  rvalid;
    logic [DATA_WIDTH-1:0] rdata;
  } mem_rsp_t;

endpackage

/* source/dma_reg_frontend.sv */
/*
 * DMA register frontend
 * Holds the transfer programming registers, issues IDs and tracks completion
 */
module dma_reg_frontend import dma_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  cfg_req_t cfg_req_i,
  output cfg_rsp_t cfg_rsp_o,
  output xfer_2d_t xfer_o,
  output logic     push_o,
  input  logic     full_i,
  input  logic     xfer_done_i,
  input  logic     busy_i
);

  xfer_2d_t              regs_q;
  logic [ID_WIDTH-1:0]   next_id_q;
  logic [ID_WIDTH-1:0]   done_id_q;
  logic                  launch_rd;
  logic                  gnt;
  logic                  rvalid_q;
  logic [DATA_WIDTH-1:0] rdata_d;
  logic [DATA_WIDTH-1:0] rdata_q;

  // A launch read stalls while the queue has no room
  assign launch_rd = cfg_req_i.req && !cfg_req_i.we && (cfg_req_i.addr == reg_next_id);
  assign gnt       = cfg_req_i.req && !(launch_rd && full_i);
  assign push_o    = launch_rd && !full_i;
  assign xfer_o    = regs_q;

  // ------------------------------------------------------------------------
  // Programming registers
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      regs_q <= '0;
    end else if (cfg_req_i.req && cfg_req_i.we) begin
      case (cfg_req_i.addr)
        reg_src:        regs_q.src        <= cfg_req_i.wdata;
        reg_dst:        regs_q.dst        <= cfg_req_i.wdata;
        reg_len:        regs_q.len        <= cfg_req_i.wdata;
        reg_src_stride: regs_q.src_stride <= cfg_req_i.wdata;
        reg_dst_stride: regs_q.dst_stride <= cfg_req_i.wdata;
        reg_reps:       regs_q.reps       <= cfg_req_i.wdata;
        default:        ;
      endcase
    end
  end

  // ID issue and completion counters
  // The first launch gets ID 1
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      next_id_q <= ID_WIDTH'(1);
      done_id_q <= '0;
    end else begin
      if (push_o) begin
        next_id_q <= next_id_q + 1'b1;
      end
      if (xfer_done_i) begin
        done_id_q <= done_id_q + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Read response
  // ------------------------------------------------------------------------

  always_comb begin
    rdata_d = '0;
    if (!cfg_req_i.we) begin
      case (cfg_req_i.addr)
        reg_src:        rdata_d = regs_q.src;
        reg_dst:        rdata_d = regs_q.dst;
        reg_len:        rdata_d = regs_q.len;
        reg_src_stride: rdata_d = regs_q.src_stride;
        reg_dst_stride: rdata_d = regs_q.dst_stride;
        reg_reps:       rdata_d = regs_q.reps;
        reg_next_id:    rdata_d = {{(DATA_WIDTH - ID_WIDTH){1'b0}}, next_id_q};
        reg_done_id:    rdata_d = {{(DATA_WIDTH - ID_WIDTH){1'b0}}, done_id_q};
        reg_status:     rdata_d = {{(DATA_WIDTH - 1){1'b0}}, busy_i};
        default:        rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      rvalid_q <= gnt;
      rdata_q  <= gnt ? rdata_d : '0;
    end
  end

  assign cfg_rsp_o.gnt    = gnt;
  assign cfg_rsp_o.rvalid = rvalid_q;
  assign cfg_rsp_o.rdata  = rdata_q;

endmodule

/* source/dma_req_fifo.sv */
/*
 * DMA request queue
 * Circular buffer of 2D transfers between the frontend and the midend
 */
module dma_req_fifo import dma_pkg::*; #(
  parameter int unsigned DEPTH = 4
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     push_i,
  input  xfer_2d_t data_i,
  output logic     full_o,
  output logic     valid_o,
  output xfer_2d_t data_o,
  input  logic     pop_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  xfer_2d_t           mem_q [DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic               do_push;
  logic               do_pop;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && valid_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap explicitly so any depth works
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

endmodule

/* source/dma_2d_midend.sv */
/*
 * DMA 2D midend
 * Walks a queued transfer row by row and hands 1D rows to the backend
 */
module dma_2d_midend import dma_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     xfer_valid_i,
  input  xfer_2d_t xfer_i,
  output logic     pop_o,
  output logic     row_valid_o,
  output row_req_t row_o,
  input  logic     row_ready_i,
  output logic     busy_o
);

  typedef enum logic {
    mid_idle,
    mid_rows
  } state_e;

  state_e                state_q;
  logic [ADDR_WIDTH-1:0] src_q;
  logic [ADDR_WIDTH-1:0] dst_q;
  logic [ADDR_WIDTH-1:0] len_q;
  logic [ADDR_WIDTH-1:0] src_stride_q;
  logic [ADDR_WIDTH-1:0] dst_stride_q;
  logic [DATA_WIDTH-1:0] rows_left_q;
  logic                  last_row;
  logic                  row_accept;

  assign pop_o       = xfer_valid_i && (state_q == mid_idle);
  assign row_valid_o = (state_q == mid_rows);
  assign last_row    = (rows_left_q == DATA_WIDTH'(1));
  assign row_accept  = row_valid_o && row_ready_i;
  assign busy_o      = (state_q == mid_rows);

  assign row_o.src  = src_q;
  assign row_o.dst  = dst_q;
  assign row_o.len  = len_q;
  assign row_o.last = last_row;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= mid_idle;
    end else begin
      case (state_q)
        mid_idle: if (xfer_valid_i) state_q <= mid_rows;
        mid_rows: if (row_accept && last_row) state_q <= mid_idle;
        default:  state_q <= mid_idle;
      endcase
    end
  end

  // Running addresses and remaining rows
  // A reps count of zero still gives one row
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      src_q        <= xfer_i.src;
      dst_q        <= xfer_i.dst;
      len_q        <= xfer_i.len;
      src_stride_q <= xfer_i.src_stride;
      dst_stride_q <= xfer_i.dst_stride;
      rows_left_q  <= (xfer_i.reps == '0) ? DATA_WIDTH'(1) : xfer_i.reps;
    end else if (row_accept) begin
      src_q       <= src_q + src_stride_q;
      dst_q       <= dst_q + dst_stride_q;
      rows_left_q <= rows_left_q - 1'b1;
    end
  end

endmodule

/* source/dma_copy_backend.sv */
/*
 * DMA copy backend
 * Copies each row one word at a time over the TCDM or the external port
 */
module dma_copy_backend import dma_pkg::*; #(
  parameter logic [ADDR_WIDTH-1:0] TCDM_BASE = 32'h1000_0000,
  parameter logic [ADDR_WIDTH-1:0] TCDM_SIZE = 32'h0001_0000
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     row_valid_i,
  input  row_req_t row_i,
  output logic     row_ready_o,
  output mem_req_t tcdm_req_o,
  input  mem_rsp_t tcdm_rsp_i,
  output mem_req_t ext_req_o,
  input  mem_rsp_t ext_rsp_i,
  output logic     xfer_done_o,
  output logic     busy_o
);

  localparam logic [ADDR_WIDTH-1:0] WORD_BYTES = ADDR_WIDTH'(DATA_WIDTH / 8);

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_wait_data,
    st_write
  } state_e;

  state_e                state_q, state_d;
  logic [ADDR_WIDTH-1:0] src_q;
  logic [ADDR_WIDTH-1:0] dst_q;
  logic [ADDR_WIDTH-1:0] left_q;
  logic                  last_q;
  logic [DATA_WIDTH-1:0] data_q;
  logic                  done_q, done_d;
  logic [ADDR_WIDTH-1:0] acc_addr;
  logic                  acc_tcdm;
  logic                  acc_req;
  logic                  acc_gnt;
  logic                  acc_rvalid;
  logic [DATA_WIDTH-1:0] acc_rdata;

  // ------------------------------------------------------------------------
  // Port decode
  // ------------------------------------------------------------------------

  assign acc_addr = (state_q == st_write) ? dst_q : src_q;
  // Unsigned offset check covers both window bounds
  assign acc_tcdm = (acc_addr - TCDM_BASE) < TCDM_SIZE;
  assign acc_req  = (state_q == st_read) || (state_q == st_write);

  assign tcdm_req_o.req   = acc_req && acc_tcdm;
  assign tcdm_req_o.we    = (state_q == st_write);
  assign tcdm_req_o.addr  = acc_addr;
  assign tcdm_req_o.wdata = data_q;
  assign ext_req_o.req    = acc_req && !acc_tcdm;
  assign ext_req_o.we     = (state_q == st_write);
  assign ext_req_o.addr   = acc_addr;
  assign ext_req_o.wdata  = data_q;

  assign acc_gnt    = acc_tcdm ? tcdm_rsp_i.gnt : ext_rsp_i.gnt;
  assign acc_rvalid = acc_tcdm ? tcdm_rsp_i.rvalid : ext_rsp_i.rvalid;
  assign acc_rdata  = acc_tcdm ? tcdm_rsp_i.rdata : ext_rsp_i.rdata;

  assign row_ready_o = (state_q == st_idle);
  assign xfer_done_o = done_q;
  assign busy_o      = (state_q != st_idle) || done_q;

  // ------------------------------------------------------------------------
  // Copy FSM
  // ------------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    done_d  = 1'b0;
    case (state_q)
      st_idle: begin
        if (row_valid_i) begin
          if (row_i.len == '0) begin
            done_d = row_i.last;
          end else begin
            state_d = st_read;
          end
        end
      end
      st_read:      if (acc_gnt) state_d = st_wait_data;
      st_wait_data: if (acc_rvalid) state_d = st_write;
      st_write: begin
        if (acc_gnt) begin
          state_d = (left_q <= WORD_BYTES) ? st_idle : st_read;
          done_d  = (left_q <= WORD_BYTES) && last_q;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= st_idle;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (row_ready_o && row_valid_i) begin
      src_q  <= row_i.src;
      dst_q  <= row_i.dst;
      left_q <= row_i.len;
      last_q <= row_i.last;
    end else if (state_q == st_write && acc_gnt) begin
      src_q  <= src_q + WORD_BYTES;
      dst_q  <= dst_q + WORD_BYTES;
      left_q <= left_q - WORD_BYTES;
    end
    if (state_q == st_wait_data && acc_rvalid) begin
      data_q <= acc_rdata;
    end
  end

endmodule

/* source/dma_top.sv */
/*
 * DMA engine top level
 * Frontend, request queue, 2D midend and copy backend
 */
module dma_top import dma_pkg::*; #(
  parameter int unsigned           QUEUE_DEPTH = 4,
  parameter logic [ADDR_WIDTH-1:0] TCDM_BASE   = 32'h1000_0000,
  parameter logic [ADDR_WIDTH-1:0] TCDM_SIZE   = 32'h0001_0000
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  cfg_req_t cfg_req_i,
  output cfg_rsp_t cfg_rsp_o,
  output mem_req_t tcdm_req_o,
  input  mem_rsp_t tcdm_rsp_i,
  output mem_req_t ext_req_o,
  input  mem_rsp_t ext_rsp_i,
  output logic     term_event_o,
  output logic     busy_o
);

  xfer_2d_t fe_xfer;
  xfer_2d_t queue_xfer;
  row_req_t row;
  logic     fe_push;
  logic     queue_full;
  logic     queue_valid;
  logic     mid_pop;
  logic     row_valid;
  logic     row_ready;
  logic     mid_busy;
  logic     be_busy;
  logic     xfer_done;

  // Busy covers queued, splitting and copying transfers
  assign busy_o       = queue_valid | mid_busy | be_busy;
  assign term_event_o = xfer_done;

  // ------------------------------------------------------------------------
  // Frontend and queue
  // ------------------------------------------------------------------------

  dma_reg_frontend i_frontend (
    .clk_i       ( clk_i      ),
    .reset_i     ( reset_i    ),
    .cfg_req_i   ( cfg_req_i  ),
    .cfg_rsp_o   ( cfg_rsp_o  ),
    .xfer_o      ( fe_xfer    ),
    .push_o      ( fe_push    ),
    .full_i      ( queue_full ),
    .xfer_done_i ( xfer_done  ),
    .busy_i      ( busy_o     )
  );

  dma_req_fifo #(
    .DEPTH ( QUEUE_DEPTH )
  ) i_req_fifo (
    .clk_i   ( clk_i       ),
    .reset_i ( reset_i     ),
    .push_i  ( fe_push     ),
    .data_i  ( fe_xfer     ),
    .full_o  ( queue_full  ),
    .valid_o ( queue_valid ),
    .data_o  ( queue_xfer  ),
    .pop_i   ( mid_pop     )
  );

  // ------------------------------------------------------------------------
  // Midend and backend
  // ------------------------------------------------------------------------

  dma_2d_midend i_midend (
    .clk_i        ( clk_i       ),
    .reset_i      ( reset_i     ),
    .xfer_valid_i ( queue_valid ),
    .xfer_i       ( queue_xfer  ),
    .pop_o        ( mid_pop     ),
    .row_valid_o  ( row_valid   ),
    .row_o        ( row         ),
    .row_ready_i  ( row_ready   ),
    .busy_o       ( mid_busy    )
  );

  dma_copy_backend #(
    .TCDM_BASE ( TCDM_BASE ),
    .TCDM_SIZE ( TCDM_SIZE )
  ) i_backend (
    .clk_i       ( clk_i      ),
    .reset_i     ( reset_i    ),
    .row_valid_i ( row_valid  ),
    .row_i       ( row        ),
    .row_ready_o ( row_ready  ),
    .tcdm_req_o  ( tcdm_req_o ),
    .tcdm_rsp_i  ( tcdm_rsp_i ),
    .ext_req_o   ( ext_req_o  ),
    .ext_rsp_i   ( ext_rsp_i  ),
    .xfer_done_o ( xfer_done  ),
    .busy_o      ( be_busy    )
  );

endmodule

/* tb/tb_dma_top.sv */
/*
 * DMA engine testbench
 * Directed tests with TCDM and external memory models on the two ports
 */
module tb_dma_top import dma_pkg::*; ();

  localparam logic [31:0] TCDM_BASE     = 32'h1000_0000;
  localparam logic [31:0] EXT_BASE      = 32'h8000_0000;
  localparam int          CFG_TIMEOUT   = 1000;
  localparam int          EVENT_TIMEOUT = 20000;

  logic        clk_i;
  logic        reset_i;
  cfg_req_t    cfg_req;
  cfg_rsp_t    cfg_rsp;
  mem_req_t    tcdm_req;
  mem_rsp_t    tcdm_rsp;
  mem_req_t    ext_req;
  mem_rsp_t    ext_rsp;
  logic        term_event;
  logic        busy;

  logic [31:0] tcdm_mem [1024];
  logic [31:0] ext_mem [1024];
  mem_req_t    tcdm_seen;
  mem_req_t    ext_seen;
  logic [31:0] rng;
  logic [3:0]  stall_thr;
  int          req_cycles;
  int          term_count;
  bit          busy_watch;
  bit          busy_drop;
  int          errors;
  int          tests_run;
  logic [31:0] exp_id;

  dma_top #(
    .QUEUE_DEPTH ( 4          ),
    .TCDM_BASE   ( TCDM_BASE  ),
    .TCDM_SIZE   ( 32'h0001_0000 )
  ) DUT (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .cfg_req_i    ( cfg_req    ),
    .cfg_rsp_o    ( cfg_rsp    ),
    .tcdm_req_o   ( tcdm_req   ),
    .tcdm_rsp_i   ( tcdm_rsp   ),
    .ext_req_o    ( ext_req    ),
    .ext_rsp_i    ( ext_rsp    ),
    .term_event_o ( term_event ),
    .busy_o       ( busy       )
  );

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Memory contents depend on the full byte address
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return (a ^ 32'h5a5a_c0de) + {a[15:0], a[31:16]};
  endfunction

  function automatic logic [31:0] peek(input logic [31:0] a);
    if (a[31:16] == TCDM_BASE[31:16]) begin
      return tcdm_mem[a[11:2]];
    end
    return ext_mem[a[11:2]];
  endfunction

  // ------------------------------------------------------------------------
  // Memory models and event monitor on the falling edge
  // ------------------------------------------------------------------------

  always @(negedge clk_i) begin
    rng = xorshift32(rng);
    // Handshakes of the last rising edge
    tcdm_rsp.rvalid = 1'b0;
    tcdm_rsp.rdata  = '0;
    if (tcdm_seen.req && tcdm_rsp.gnt) begin
      if (tcdm_seen.we) begin
        tcdm_mem[tcdm_seen.addr[11:2]] = tcdm_seen.wdata;
      end else begin
        tcdm_rsp.rvalid = 1'b1;
        tcdm_rsp.rdata  = tcdm_mem[tcdm_seen.addr[11:2]];
      end
    end
    ext_rsp.rvalid = 1'b0;
    ext_rsp.rdata  = '0;
    if (ext_seen.req && ext_rsp.gnt) begin
      if (ext_seen.we) begin
        ext_mem[ext_seen.addr[11:2]] = ext_seen.wdata;
      end else begin
        ext_rsp.rvalid = 1'b1;
        ext_rsp.rdata  = ext_mem[ext_seen.addr[11:2]];
      end
    end
    // Requests hold until the next rising edge
    tcdm_seen    = tcdm_req;
    ext_seen     = ext_req;
    tcdm_rsp.gnt = tcdm_req.req && (rng[3:0] >= stall_thr);
    ext_rsp.gnt  = ext_req.req && (rng[11:8] >= stall_thr);
    if (tcdm_req.req || ext_req.req) begin
      req_cycles++;
    end
    if (term_event) begin
      term_count++;
      busy_watch = 1'b0;
    end else if (busy_watch && !busy) begin
      busy_drop = 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    tests_run++;
    if (errors == start_errors) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - start_errors);
    end
  endtask

  // One access, granted at a rising edge and answered in the next cycle
  task automatic cfg_access(input bit we, input logic [9:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int cycles;
    bit granted;
    cycles  = 0;
    granted = 1'b0;
    rdata   = '0;
    @(negedge clk_i);
    cfg_req.req   = 1'b1;
    cfg_req.we    = we;
    cfg_req.addr  = addr;
    cfg_req.wdata = wdata;
    // Grant as the rising edge takes it
    while (!granted && cycles < CFG_TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
      granted = cfg_rsp.gnt;
    end
    @(negedge clk_i);
    if (!granted) begin
      $display("timeout waiting for a register grant at offset %h", addr);
      errors++;
    end else if (!cfg_rsp.rvalid) begin
      $display("no register response one cycle after the grant at offset %h", addr);
      errors++;
    end else begin
      rdata = cfg_rsp.rdata;
    end
    cfg_req = '0;
  endtask

  task automatic cfg_write(input logic [9:0] addr, input logic [31:0] wdata);
    logic [31:0] wr_rsp;
    cfg_access(1'b1, addr, wdata, wr_rsp);
    check("cfg_rsp.rdata", wr_rsp, 32'h0);
  endtask

  task automatic cfg_read(input logic [9:0] addr, output logic [31:0] rdata);
    cfg_access(1'b0, addr, '0, rdata);
  endtask

  task automatic wait_event(input int target);
    int cycles;
    cycles = 0;
    while (term_count < target && cycles < EVENT_TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (term_count < target) begin
      $display("timeout waiting for completion, saw %0d of %0d events", term_count, target);
      errors++;
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (busy && cycles < EVENT_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (busy) begin
      $display("timeout waiting for the engine to go idle");
      errors++;
    end
  endtask

  task automatic fill_mems();
    for (int i = 0; i < 1024; i++) begin
      tcdm_mem[i] = fill_word(TCDM_BASE + 32'(i * 4));
      ext_mem[i]  = fill_word(EXT_BASE + 32'(i * 4));
    end
  endtask

  task automatic launch_xfer(input logic [31:0] src, input logic [31:0] dst,
                             input logic [31:0] len, input logic [31:0] ss,
                             input logic [31:0] ds, input logic [31:0] reps,
                             output logic [31:0] id);
    cfg_write(reg_src, src);
    cfg_write(reg_dst, dst);
    cfg_write(reg_len, len);
    cfg_write(reg_src_stride, ss);
    cfg_write(reg_dst_stride, ds);
    cfg_write(reg_reps, reps);
    cfg_read(reg_next_id, id);
    check("next_id", id, exp_id);
    exp_id++;
  endtask

  // Row k, word j lands at dst + k*ds + 4j
  task automatic check_copy(input logic [31:0] src, input logic [31:0] dst,
                            input logic [31:0] len, input logic [31:0] ss,
                            input logic [31:0] ds, input int rows);
    logic [31:0] da;
    logic [31:0] sa;
    for (int k = 0; k < rows; k++) begin
      for (int j = 0; j < int'(len / 4); j++) begin
        da = dst + 32'(k) * ds + 32'(j * 4);
        sa = src + 32'(k) * ss + 32'(j * 4);
        check($sformatf("mem[%h]", da), peek(da), fill_word(sa));
      end
    end
  endtask

  // ------------------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------------------

  task automatic test_reg_readback();
    int          start;
    logic [31:0] vals [6];
    logic [31:0] rd;
    start   = errors;
    vals[0] = 32'h1234_5678;
    vals[1] = 32'h9abc_def0;
    vals[2] = 32'h0000_0040;
    vals[3] = 32'h0000_0104;
    vals[4] = 32'h0000_0208;
    vals[5] = 32'h0000_0007;
    for (int i = 0; i < 6; i++) begin
      cfg_write(10'(i * 4), vals[i]);
    end
    for (int i = 0; i < 6; i++) begin
      cfg_read(10'(i * 4), rd);
      check($sformatf("reg[%h]", i * 4), rd, vals[i]);
    end
    cfg_read(reg_status, rd);
    check("status", rd, 32'h0);
    report_test("reg_readback", start);
  endtask

  task automatic test_copy_1d();
    int          start;
    logic [31:0] id;
    logic [31:0] rd;
    start = errors;
    fill_mems();
    launch_xfer(EXT_BASE + 32'h100, TCDM_BASE + 32'h200, 64, 0, 0, 1, id);
    check("first id", id, 32'd1);
    wait_event(term_count + 1);
    wait_idle();
    cfg_read(reg_done_id, rd);
    check("done_id", rd, 32'd1);
    check_copy(EXT_BASE + 32'h100, TCDM_BASE + 32'h200, 64, 0, 0, 1);
    report_test("copy_1d", start);
  endtask

  task automatic test_copy_2d();
    int          start;
    logic [31:0] id;
    logic [31:0] da;
    start = errors;
    fill_mems();
    launch_xfer(TCDM_BASE + 32'h400, EXT_BASE + 32'h800, 12, 16, 20, 4, id);
    wait_event(term_count + 1);
    wait_idle();
    check_copy(TCDM_BASE + 32'h400, EXT_BASE + 32'h800, 12, 16, 20, 4);
    // Two gap words after every destination row
    for (int k = 0; k < 4; k++) begin
      for (int j = 3; j < 5; j++) begin
        da = EXT_BASE + 32'h800 + 32'(k * 20 + j * 4);
        check($sformatf("gap[%h]", da), peek(da), fill_word(da));
      end
    end
    report_test("copy_2d", start);
  endtask

  task automatic test_back_to_back();
    int          start;
    int          base;
    logic [31:0] id;
    logic [31:0] rd;
    start = errors;
    base  = term_count;
    fill_mems();
    launch_xfer(EXT_BASE, TCDM_BASE, 32, 0, 0, 1, id);
    launch_xfer(TCDM_BASE + 32'h100, TCDM_BASE + 32'h300, 32, 0, 0, 1, id);
    launch_xfer(EXT_BASE + 32'h200, EXT_BASE + 32'h600, 32, 0, 0, 1, id);
    wait_event(base + 3);
    wait_idle();
    check("term events", 32'(term_count - base), 32'd3);
    cfg_read(reg_done_id, rd);
    check("done_id", rd, exp_id - 32'd1);
    check_copy(EXT_BASE, TCDM_BASE, 32, 0, 0, 1);
    check_copy(TCDM_BASE + 32'h100, TCDM_BASE + 32'h300, 32, 0, 0, 1);
    check_copy(EXT_BASE + 32'h200, EXT_BASE + 32'h600, 32, 0, 0, 1);
    report_test("back_to_back", start);
  endtask

  task automatic test_zero_len();
    int          start;
    int          base;
    int          reqs;
    logic [31:0] id;
    logic [31:0] rd;
    start = errors;
    base  = term_count;
    reqs  = req_cycles;
    launch_xfer(EXT_BASE, TCDM_BASE, 0, 0, 0, 1, id);
    wait_event(base + 1);
    wait_idle();
    check("term events", 32'(term_count - base), 32'd1);
    check("memory req cycles", 32'(req_cycles - reqs), 32'd0);
    cfg_read(reg_done_id, rd);
    check("done_id", rd, exp_id - 32'd1);
    report_test("zero_len", start);
  endtask

  task automatic test_stall_copy();
    int          start;
    logic [31:0] id;
    start     = errors;
    fill_mems();
    stall_thr = 4'd12;
    busy_drop = 1'b0;
    launch_xfer(EXT_BASE, TCDM_BASE + 32'h800, 128, 32'h100, 32'h100, 2, id);
    busy_watch = 1'b1;
    wait_event(term_count + 1);
    @(negedge clk_i);
    if (busy_drop) begin
      $display("busy_o went low before the transfer completed");
      errors++;
    end
    check("busy_o", 32'(busy), 32'd0);
    check_copy(EXT_BASE, TCDM_BASE + 32'h800, 128, 32'h100, 32'h100, 2);
    stall_thr = 4'd4;
    report_test("stall_copy", start);
  endtask

  initial begin
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    cfg_req    = '0;
    tcdm_rsp   = '0;
    ext_rsp    = '0;
    tcdm_seen  = '0;
    ext_seen   = '0;
    rng        = 32'h1299_bcaa;
    stall_thr  = 4'd4;
    req_cycles = 0;
    term_count = 0;
    busy_watch = 1'b0;
    busy_drop  = 1'b0;
    errors     = 0;
    tests_run  = 0;
    exp_id     = 32'd1;
    fill_mems();
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    test_reg_readback();
    test_copy_1d();
    test_copy_2d();
    test_back_to_back();
    test_zero_len();
    test_stall_copy();

    $display("tests %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* project.f */
source/dma_pkg.sv
source/dma_reg_frontend.sv
source/dma_req_fifo.sv
source/dma_2d_midend.sv
source/dma_copy_backend.sv
source/dma_top.sv
tb/tb_dma_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DMA testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_dma_top -f project.f -o tb_dma_top \
  || exit 1
out=$(./obj_dir/tb_dma_top)
echo "$out"
echo "$out" | grep -q "sim passed" && exit 0 || exit 1
